//--- Bender.yml
package:
  name: tcm

export_include_dirs:
  - .

sources:
  # design, compile order
  - files:
      - tcm_pkg.sv
      - tcm_arbiter.sv
      - tcm_mem_array.sv
      - tcm_read_return.sv
      - tcm_top.sv

  # testbench
  - target: test
    files:
      - tcm_tb.sv

//--- project.f
+incdir+.
tcm_pkg.sv
tcm_arbiter.sv
tcm_mem_array.sv
tcm_read_return.sv
tcm_top.sv
tcm_tb.sv

//--- tcm_arbiter.sv
//////////////////////////////////////////////////
// input side of the memory subsystem
// picks one request per cycle, load/store first,
// and tags each read with its owner for routing
//////////////////////////////////////////////////

`include "tcm_consts.svh"

module tcm_arbiter
  import tcm_pkg::*;
(
  input  logic       bus,
  input  logic       rst_n,
  // fetch port
  input  logic       ifu_vld,
  input  tcm_adr_t   ifu_adr,
  output logic       ifu_rdy,
  // load/store port
  input  logic       lsu_vld,
  input  logic       lsu_wen,
  input  tcm_adr_t   lsu_adr,
  input  tcm_ben_t   lsu_ben,
  input  tcm_data_t  lsu_wdt,
  // towards the array
  output logic       mem_vld,
  output logic       mem_wen,
  output tcm_widx_t  mem_widx,
  output tcm_ben_t   mem_ben,
  output tcm_data_t  mem_wdt,
  // towards read return
  output tcm_owner_e rd_owner,
  output tcm_ben_t   rd_ben
);

  logic ifu_acc;
  logic rd_acc;

  //////////////////////////////////////////////////
  // grant
  //////////////////////////////////////////////////

  // load/store always wins, fetch waits
  assign ifu_rdy = ~lsu_vld;
  assign ifu_acc = ifu_vld & ifu_rdy;

  assign mem_vld  = lsu_vld | ifu_acc;
  assign mem_wen  = lsu_vld & lsu_wen;
  // low address bits dropped, no misaligned support
  assign mem_widx = lsu_vld ? lsu_adr[`TCM_AW-1:$clog2(`TCM_BW)]
                            : ifu_adr[`TCM_AW-1:$clog2(`TCM_BW)];
  // fetch reads the whole word
  assign mem_ben  = lsu_vld ? lsu_ben : '1;
  // only meaningful on load/store writes
  assign mem_wdt  = lsu_wdt;

  // any read issued this cycle
  assign rd_acc = mem_vld & ~mem_wen;

  //////////////////////////////////////////////////
  // owner tag
  //////////////////////////////////////////////////

  // writes and idle cycles leave no read behind
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      rd_owner <= OWN_NONE;
    end else if (lsu_vld) begin
      rd_owner <= lsu_wen ? OWN_NONE : OWN_LSU;
    end else if (ifu_acc) begin
      rd_owner <= OWN_IFU;
    end else begin
      rd_owner <= OWN_NONE;
    end
  end

  // lane mask for the pending read
  always_ff @(posedge bus) begin
    if (rd_acc) begin
      rd_ben <= mem_ben;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // fetch never granted alongside load/store
  a_no_ifu_rdy: assert property (@(posedge bus) disable iff (!rst_n)
    lsu_vld |-> !ifu_rdy);

endmodule : tcm_arbiter

//--- tcm_consts.svh
//////////////////////////////////////////////////
// size constants for the tightly coupled memory
// one size per build, included by the package and
// by every module that slices addresses or lanes
//////////////////////////////////////////////////

`ifndef TCM_CONSTS_SVH
`define TCM_CONSTS_SVH

// byte address width, 4 kB of memory
`define TCM_AW 12

// data word width
`define TCM_DW 32

// byte enable width, one bit per byte lane
`define TCM_BW 4

// number of words in the array
// must match 2**TCM_AW / TCM_BW
`define TCM_WORDS 1024

`endif

//--- tcm_mem_array.sv
//////////////////////////////////////////////////
// processing part, single port word array
// byte lane writes, whole word registered reads
//////////////////////////////////////////////////

`include "tcm_consts.svh"

module tcm_mem_array
  import tcm_pkg::*;
(
  input  logic      bus,
  // single access port from the arbiter
  input  logic      mem_vld,
  input  logic      mem_wen,
  input  tcm_widx_t mem_widx,
  input  tcm_ben_t  mem_ben,
  input  tcm_data_t mem_wdt,
  // read data, valid one cycle after a read
  output tcm_data_t mem_rdt
);

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  // inferable block memory, no init
  tcm_data_t mem [0:`TCM_WORDS-1];

  //////////////////////////////////////////////////
  // access
  //////////////////////////////////////////////////

  // write updates the array on the accept edge,
  // so a read one cycle later sees new data
  always_ff @(posedge bus) begin
    if (mem_vld && mem_wen) begin
      for (int b = 0; b < `TCM_BW; b++) begin
        // only enabled lanes change
        if (mem_ben[b]) begin
          mem[mem_widx][8*b +: 8] <= mem_wdt[8*b +: 8];
        end
      end
    end
  end

  // read port, whole word
  // holds its value in cycles without a read
  always_ff @(posedge bus) begin
    if (mem_vld && !mem_wen) begin
      mem_rdt <= mem[mem_widx];
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // a known request from the arbiter whenever one is issued
  // guards against stray X from either port reaching the array
  a_req_known: assert property (@(posedge bus)
    mem_vld |-> !$isunknown({mem_widx, mem_wen}));

endmodule : tcm_mem_array

//--- tcm_pkg.sv
//////////////////////////////////////////////////
// shared types for the memory subsystem
// vector typedefs for addresses, data and byte
// enables, plus the read owner encoding
//////////////////////////////////////////////////

`include "tcm_consts.svh"

package tcm_pkg;

  // byte address as seen on both ports
  typedef logic [`TCM_AW-1:0] tcm_adr_t;

  // word index, byte address without the lane bits
  typedef logic [`TCM_AW-$clog2(`TCM_BW)-1:0] tcm_widx_t;

  // data word
  typedef logic [`TCM_DW-1:0] tcm_data_t;

  // byte enables, bit n covers byte n
  typedef logic [`TCM_BW-1:0] tcm_ben_t;

  // who gets the read issued last cycle
  typedef enum logic [1:0] {
    OWN_NONE = 2'd0,
    OWN_IFU  = 2'd1,
    OWN_LSU  = 2'd2
  } tcm_owner_e;

endpackage : tcm_pkg

//--- tcm_read_return.sv
//////////////////////////////////////////////////
// output side of the memory subsystem
// routes each read word to its port, masks lanes
// on load/store and holds the last word per port
//////////////////////////////////////////////////

`include "tcm_consts.svh"

module tcm_read_return
  import tcm_pkg::*;
(
  input  logic       bus,
  input  logic       rst_n,
  // tag and mask of the read issued last cycle
  input  tcm_owner_e rd_owner,
  input  tcm_ben_t   rd_ben,
  // raw word from the array
  input  tcm_data_t  mem_rdt,
  // fetch response
  output tcm_data_t  ifu_rdt,
  output logic       ifu_rvl,
  // load/store response
  output tcm_data_t  lsu_rdt,
  output logic       lsu_rvl
);

  tcm_data_t lsu_msk;

  // disabled lanes read as zero
  always_comb begin
    for (int b = 0; b < `TCM_BW; b++) begin
      lsu_msk[8*b +: 8] = rd_ben[b] ? mem_rdt[8*b +: 8] : 8'h00;
    end
  end

  //////////////////////////////////////////////////
  // holding registers
  //////////////////////////////////////////////////

  // strobes pulse one cycle, data held until next response
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      ifu_rvl <= 1'b0;
      lsu_rvl <= 1'b0;
      ifu_rdt <= '0;
      lsu_rdt <= '0;
    end else begin
      ifu_rvl <= (rd_owner == OWN_IFU);
      lsu_rvl <= (rd_owner == OWN_LSU);
      if (rd_owner == OWN_IFU) begin
        ifu_rdt <= mem_rdt;
      end
      if (rd_owner == OWN_LSU) begin
        lsu_rdt <= lsu_msk;
      end
    end
  end

  // one response per cycle at most
  a_rvl_onehot: assert property (@(posedge bus) disable iff (!rst_n)
    !(ifu_rvl && lsu_rvl));

endmodule : tcm_read_return

//--- tcm_tb.sv
//////////////////////////////////////////////////
// testbench for the tightly coupled memory
// drives both ports from an LFSR, keeps a reference
// memory and checks the responses with assertions
//////////////////////////////////////////////////

`include "tcm_consts.svh"

module tcm_tb
  import tcm_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int lane_bits = $clog2(`TCM_BW);
  // test lengths in cycles, for the watchdog
  localparam int fill_cycles  = `TCM_WORDS + 10;
  localparam int wtr_cycles   = 8 * 6 + 6;
  localparam int lanes_cycles = 16 * 6 + 6;
  localparam int stall_cycles = 8 * 12 + 6;
  localparam int b2b_cycles   = 200 + 6;
  localparam int hold_cycles  = 6 * 18 + 6;
  localparam int wd_cycles    = fill_cycles + wtr_cycles + lanes_cycles + stall_cycles
                              + b2b_cycles + hold_cycles + 200;

  logic      bus;
  logic      rst_n;
  logic      ifu_vld;
  tcm_adr_t  ifu_adr;
  logic      ifu_rdy;
  tcm_data_t ifu_rdt;
  logic      ifu_rvl;
  logic      lsu_vld;
  logic      lsu_wen;
  tcm_adr_t  lsu_adr;
  tcm_ben_t  lsu_ben;
  tcm_data_t lsu_wdt;
  tcm_data_t lsu_rdt;
  logic      lsu_rvl;

  // reference model state
  tcm_data_t   ref_mem [0:`TCM_WORDS-1];
  tcm_widx_t   lsu_widx;
  tcm_widx_t   ifu_widx;
  // one-deep queue per port, then the expected outputs
  logic        lsu_q_vld;
  logic        ifu_q_vld;
  tcm_data_t   lsu_q_dat;
  tcm_data_t   ifu_q_dat;
  logic        lsu_exp_vld;
  logic        ifu_exp_vld;
  tcm_data_t   lsu_exp_rdt;
  tcm_data_t   ifu_exp_rdt;
  logic        resp_seen;

  logic [31:0] lfsr_state;
  string       test_name;
  int          err_cnt;
  int          err_at_start;
  int          pass_cnt;
  int          fail_cnt;

  tcm_top dut0 (.*);

  // clock, 4 ns period
  initial begin
    bus = 1'b0;
    forever #2 bus = ~bus;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // taps 32, 22, 2, 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // lower 256 words, random lane bits that the DUT ignores
  function automatic tcm_adr_t rand_adr();
    logic [7:0] w;
    logic [1:0] l;
    w = 8'(rand_bits(8));
    l = 2'(rand_bits(2));
    return {2'b00, w, l};
  endfunction

  // disabled lanes read as zero
  function automatic tcm_data_t lane_mask(input tcm_data_t d, input tcm_ben_t b);
    tcm_data_t m;
    for (int i = 0; i < `TCM_BW; i++) begin
      m[8*i +: 8] = b[i] ? d[8*i +: 8] : 8'h00;
    end
    return m;
  endfunction

  // fill pattern, every address bit shows up twice
  function automatic tcm_data_t fill_word(input tcm_widx_t w);
    return {6'h2a, w, 6'h15, ~w};
  endfunction

  // one cycle of stimulus, applied on the falling edge
  task automatic drive_cycle(input logic iv, input tcm_adr_t ia, input logic lv,
                             input logic lw, input tcm_adr_t la, input tcm_ben_t lb,
                             input tcm_data_t ld);
    @(negedge bus);
    ifu_vld = iv;
    ifu_adr = ia;
    lsu_vld = lv;
    lsu_wen = lw;
    lsu_adr = la;
    lsu_ben = lb;
    lsu_wdt = ld;
  endtask

  task automatic drive_idle();
    drive_cycle(1'b0, '0, 1'b0, 1'b0, '0, '0, '0);
  endtask

  // wait for a response strobe, 4 cycles at most
  task automatic await_resp(input bit on_lsu);
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < 4 && !seen; i++) begin
      @(negedge bus);
      seen = on_lsu ? lsu_rvl : ifu_rvl;
    end
    if (!seen) begin
      err_cnt++;
      $display("no %s response within 4 cycles in test %s", on_lsu ? "lsu" : "ifu",
               test_name);
    end
  endtask

  task automatic value_error(input string what, input tcm_data_t exp, input tcm_data_t act);
    err_cnt++;
    $display("** Error %s: %s expected %h actual %h", test_name, what, exp, act);
  endtask

  task automatic flag_error(input string msg);
    err_cnt++;
    $display("%s in test %s", msg, test_name);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_at_start = err_cnt;
  endtask

  // drain the pipeline, then one line per test
  task automatic finish_test();
    drive_idle();
    repeat (4) @(negedge bus);
    if (err_cnt == err_at_start) begin
      pass_cnt++;
      $display("test %-16s ok", test_name);
    end else begin
      fail_cnt++;
      $display("test %-16s failed, %0d errors", test_name, err_cnt - err_at_start);
    end
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  assign lsu_widx = lsu_adr[`TCM_AW-1:lane_bits];
  assign ifu_widx = ifu_adr[`TCM_AW-1:lane_bits];

  // byte lane write rule
  always @(posedge bus) begin
    if (lsu_vld && lsu_wen) begin
      for (int b = 0; b < `TCM_BW; b++) begin
        if (lsu_ben[b]) begin
          ref_mem[lsu_widx][8*b +: 8] <= lsu_wdt[8*b +: 8];
        end
      end
    end
  end

  // accept at edge k, response visible after edge k+1
  always @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      lsu_q_vld   <= 1'b0;
      ifu_q_vld   <= 1'b0;
      lsu_q_dat   <= '0;
      ifu_q_dat   <= '0;
      lsu_exp_vld <= 1'b0;
      ifu_exp_vld <= 1'b0;
      lsu_exp_rdt <= '0;
      ifu_exp_rdt <= '0;
      resp_seen   <= 1'b0;
    end else begin
      lsu_exp_vld <= lsu_q_vld;
      ifu_exp_vld <= ifu_q_vld;
      if (lsu_q_vld) begin
        lsu_exp_rdt <= lsu_q_dat;
      end
      if (ifu_q_vld) begin
        ifu_exp_rdt <= ifu_q_dat;
      end
      resp_seen <= resp_seen | lsu_exp_vld | ifu_exp_vld;
      // load/store always wins, fetch only when it is idle
      lsu_q_vld <= lsu_vld && !lsu_wen;
      ifu_q_vld <= ifu_vld && !lsu_vld;
      lsu_q_dat <= lane_mask(ref_mem[lsu_widx], lsu_ben);
      ifu_q_dat <= ref_mem[ifu_widx];
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  a_reset_idle: assert property (@(posedge bus) disable iff (!rst_n)
    (!resp_seen && !lsu_exp_vld && !ifu_exp_vld) |->
      (!ifu_rvl && !lsu_rvl && ifu_rdt == '0 && lsu_rdt == '0))
    else flag_error("response outputs not idle before the first read");
  a_ifu_rdy: assert property (@(posedge bus) disable iff (!rst_n) ifu_rdy == !lsu_vld)
    else value_error("ifu_rdy", tcm_data_t'(!$sampled(lsu_vld)),
                     tcm_data_t'($sampled(ifu_rdy)));
  a_lsu_strobe: assert property (@(posedge bus) disable iff (!rst_n) lsu_rvl == lsu_exp_vld)
    else value_error("lsu_rvl", tcm_data_t'($sampled(lsu_exp_vld)),
                     tcm_data_t'($sampled(lsu_rvl)));
  a_ifu_strobe: assert property (@(posedge bus) disable iff (!rst_n) ifu_rvl == ifu_exp_vld)
    else value_error("ifu_rvl", tcm_data_t'($sampled(ifu_exp_vld)),
                     tcm_data_t'($sampled(ifu_rvl)));
  a_lsu_data: assert property (@(posedge bus) disable iff (!rst_n) lsu_rdt == lsu_exp_rdt)
    else value_error("lsu_rdt", $sampled(lsu_exp_rdt), $sampled(lsu_rdt));
  a_ifu_data: assert property (@(posedge bus) disable iff (!rst_n) ifu_rdt == ifu_exp_rdt)
    else value_error("ifu_rdt", $sampled(ifu_exp_rdt), $sampled(ifu_rdt));
  // no response, no change
  a_lsu_hold: assert property (@(posedge bus) disable iff (!rst_n)
    !lsu_exp_vld |-> $stable(lsu_rdt))
    else flag_error("lsu_rdt changed without a response");
  a_ifu_hold: assert property (@(posedge bus) disable iff (!rst_n)
    !ifu_exp_vld |-> $stable(ifu_rdt))
    else flag_error("ifu_rdt changed without a response");
  a_rvl_excl: assert property (@(posedge bus) disable iff (!rst_n) !(ifu_rvl && lsu_rvl))
    else flag_error("both response strobes high together");

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    tcm_adr_t  a;
    tcm_adr_t  fa;
    tcm_data_t d;
    logic      lv;
    lfsr_state = 32'h36ab;
    err_cnt = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    rst_n = 1'b0;
    ifu_vld = 1'b0;
    ifu_adr = '0;
    lsu_vld = 1'b0;
    lsu_wen = 1'b0;
    lsu_adr = '0;
    lsu_ben = '0;
    lsu_wdt = '0;

    // reset, then fill every word by writes only
    start_test("reset_idle");
    repeat (2) @(posedge bus);
    @(negedge bus);
    rst_n = 1'b1;
    for (int w = 0; w < `TCM_WORDS; w++) begin
      drive_cycle(1'b0, '0, 1'b1, 1'b1, tcm_adr_t'(w << lane_bits), '1,
                  fill_word(tcm_widx_t'(w)));
    end
    finish_test();

    start_test("write_then_read");
    for (int i = 0; i < 8; i++) begin
      a = rand_adr();
      d = rand_bits(32);
      drive_cycle(1'b0, '0, 1'b1, 1'b1, a, '1, d);
      drive_cycle(1'b0, '0, 1'b1, 1'b0, a, '1, '0);
      drive_idle();
      await_resp(1'b1);
    end
    finish_test();

    // partial write, then partial read of the same word
    start_test("byte_lanes");
    for (int i = 0; i < 16; i++) begin
      a = rand_adr();
      d = rand_bits(32);
      drive_cycle(1'b0, '0, 1'b1, 1'b1, a, tcm_ben_t'(rand_bits(4)), d);
      drive_cycle(1'b0, '0, 1'b1, 1'b0, a, tcm_ben_t'(rand_bits(4)), '0);
      drive_idle();
      await_resp(1'b1);
    end
    finish_test();

    // fetch held stable while load/store keeps the array busy
    start_test("fetch_stall");
    for (int i = 0; i < 8; i++) begin
      fa = rand_adr();
      for (int n = 0; n <= (i % 4); n++) begin
        drive_cycle(1'b1, fa, 1'b1, 1'(rand_bits(1)), rand_adr(), tcm_ben_t'(rand_bits(4)),
                    rand_bits(32));
      end
      drive_cycle(1'b1, fa, 1'b0, 1'b0, '0, '0, '0);
      drive_idle();
      await_resp(1'b0);
    end
    finish_test();

    // a read every cycle, port picked at random
    start_test("back_to_back");
    fa = rand_adr();
    for (int c = 0; c < 200; c++) begin
      lv = 1'(rand_bits(1));
      drive_cycle(1'b1, fa, lv, 1'b0, rand_adr(), tcm_ben_t'(rand_bits(4)), '0);
      // fetch went through, next address
      if (!lv) begin
        fa = rand_adr();
      end
    end
    finish_test();

    // writes between responses must not disturb held data
    start_test("hold_data");
    for (int i = 0; i < 6; i++) begin
      a = rand_adr();
      drive_cycle(1'b0, '0, 1'b1, 1'b0, a, tcm_ben_t'(rand_bits(4)), '0);
      drive_idle();
      await_resp(1'b1);
      for (int n = 0; n < 4; n++) begin
        drive_cycle(1'b0, '0, 1'b1, 1'b1, a, '1, rand_bits(32));
      end
      drive_cycle(1'b1, a, 1'b0, 1'b0, '0, '0, '0);
      drive_idle();
      await_resp(1'b0);
      repeat (4) drive_idle();
    end
    finish_test();

    $display("tests passed %0d failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog over the summed test lengths
  initial begin
    #(wd_cycles * 4);
    $display("run timed out after %0d cycles in test %s", wd_cycles, test_name);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule : tcm_tb

//--- tcm_top.sv
//////////////////////////////////////////////////
// tightly coupled memory, top level
// fetch port and load/store port share one array,
// arbiter in front, read return behind
//////////////////////////////////////////////////

module tcm_top
  import tcm_pkg::*;
(
  input  logic      bus,
  input  logic      rst_n,
  // fetch port, read only
  input  logic      ifu_vld,
  input  tcm_adr_t  ifu_adr,
  output logic      ifu_rdy,
  output tcm_data_t ifu_rdt,
  output logic      ifu_rvl,
  // load/store port, never stalled
  input  logic      lsu_vld,
  input  logic      lsu_wen,
  input  tcm_adr_t  lsu_adr,
  input  tcm_ben_t  lsu_ben,
  input  tcm_data_t lsu_wdt,
  output tcm_data_t lsu_rdt,
  output logic      lsu_rvl
);

  //////////////////////////////////////////////////
  // internal wiring
  //////////////////////////////////////////////////

  // granted access
  logic       mem_vld;
  logic       mem_wen;
  tcm_widx_t  mem_widx;
  tcm_ben_t   mem_ben;
  tcm_data_t  mem_wdt;
  tcm_data_t  mem_rdt;
  // pending read tag
  tcm_owner_e rd_owner;
  tcm_ben_t   rd_ben;

  // input side
  tcm_arbiter arb0 (
    .bus      (bus),
    .rst_n    (rst_n),
    .ifu_vld  (ifu_vld),
    .ifu_adr  (ifu_adr),
    .ifu_rdy  (ifu_rdy),
    .lsu_vld  (lsu_vld),
    .lsu_wen  (lsu_wen),
    .lsu_adr  (lsu_adr),
    .lsu_ben  (lsu_ben),
    .lsu_wdt  (lsu_wdt),
    .mem_vld  (mem_vld),
    .mem_wen  (mem_wen),
    .mem_widx (mem_widx),
    .mem_ben  (mem_ben),
    .mem_wdt  (mem_wdt),
    .rd_owner (rd_owner),
    .rd_ben   (rd_ben)
  );

  // storage
  tcm_mem_array mem0 (
    .bus      (bus),
    .mem_vld  (mem_vld),
    .mem_wen  (mem_wen),
    .mem_widx (mem_widx),
    .mem_ben  (mem_ben),
    .mem_wdt  (mem_wdt),
    .mem_rdt  (mem_rdt)
  );

  // output side
  tcm_read_return ret0 (
    .bus      (bus),
    .rst_n    (rst_n),
    .rd_owner (rd_owner),
    .rd_ben   (rd_ben),
    .mem_rdt  (mem_rdt),
    .ifu_rdt  (ifu_rdt),
    .ifu_rvl  (ifu_rvl),
    .lsu_rdt  (lsu_rdt),
    .lsu_rvl  (lsu_rvl)
  );

endmodule : tcm_top
